//--- design/icache_data_store.sv
/* Data store of the instruction cache
 * One word array per way, indexed by set and word select
 * Synchronous read of both ways, refill writes word by word
 */
`timescale 1ns/1ns

module icache_data_store
  (
  input  logic                                                      clk_i,
  input  logic                                                      rd_v_i,
  input  icache_pkg::icache_addr_u                                  rd_addr_i,
  output logic [icache_pkg::num_ways-1:0][icache_pkg::instr_width-1:0] way_data_o,
  input  icache_pkg::refill_wr_s                                    refill_i
  );

  import icache_pkg::*;

  logic [index_width+word_sel_width-1:0] rd_word_addr;
  logic [index_width+word_sel_width-1:0] wr_word_addr;

  assign rd_word_addr = {rd_addr_i.fields.index, rd_addr_i.fields.word_sel};
  assign wr_word_addr = {refill_i.index, refill_i.word_sel};

  for (genvar w = 0; w < num_ways; w++)
  begin : g_way
    logic [instr_width-1:0] mem [num_sets*words_per_block];

    always_ff @(posedge clk_i)
    begin
      if (refill_i.v && (refill_i.way == way_width'(w)))
      begin
        mem[wr_word_addr] <= refill_i.data;
      end
      // Both ways read, the pipe picks one
      if (rd_v_i)
      begin
        way_data_o[w] <= mem[rd_word_addr];
      end
    end
  end

endmodule

//--- design/icache_fetch_pipe.sv
/* Fetch pipeline of the instruction cache
 * Tag-lookup and tag-verify stages, hit check and word select
 * Result pulses, miss hand-off, squash and request back-pressure
 */
`timescale 1ns/1ns

module icache_fetch_pipe
  (
  input  logic                                                      clk_i,
  input  logic                                                      reset_i,
  input  icache_pkg::icache_req_s                                   req_i,
  input  logic                                                      v_i,
  output logic                                                      ready_o,
  output logic [icache_pkg::instr_width-1:0]                        data_o,
  output logic                                                      data_v_o,
  output logic                                                      miss_v_o,
  output logic                                                      lookup_v_o,
  output icache_pkg::icache_addr_u                                  lookup_addr_o,
  output logic [icache_pkg::tag_width-1:0]                          verify_tag_o,
  input  logic [icache_pkg::num_ways-1:0]                           hit_way_i,
  input  logic [icache_pkg::way_width-1:0]                          victim_way_i,
  output logic [icache_pkg::num_ways-1:0]                           hit_update_o,
  output logic                                                      fencei_o,
  input  logic [icache_pkg::num_ways-1:0][icache_pkg::instr_width-1:0] way_data_i,
  output logic                                                      miss_o,
  output icache_pkg::icache_addr_u                                  miss_addr_o,
  output logic [icache_pkg::way_width-1:0]                          miss_way_o,
  input  logic                                                      refill_busy_i
  );

  import icache_pkg::*;

  logic                   accept;

  // Tag-lookup stage
  logic                   tl_v_r;
  icache_req_s            tl_req_r;
  logic [instr_width-1:0] tl_word;

  // Tag-verify stage
  logic                   tv_v_r;
  icache_req_s            tv_req_r;
  logic [num_ways-1:0]    tv_hit_r;
  logic [way_width-1:0]   tv_victim_r;
  logic [instr_width-1:0] tv_word_r;
  logic                   tv_fetch;
  logic                   tv_hit;
  logic                   tv_miss;

  ////////////////////////////////
  // Decode and lookup
  ////////////////////////////////
  assign accept        = v_i & ready_o;
  assign lookup_v_o    = accept;
  assign lookup_addr_o = req_i.addr;

  // While a fill runs the held miss tag goes to the tag store for its final write
  assign verify_tag_o = refill_busy_i ? tv_req_r.addr.fields.tag : tl_req_r.addr.fields.tag;

  // Word of the hitting way
  always_comb
  begin
    tl_word = way_data_i[0];
    for (int w = 1; w < num_ways; w++)
    begin
      if (hit_way_i[w])
      begin
        tl_word = way_data_i[w];
      end
    end
  end

  ////////////////////////////////
  // Verify
  ////////////////////////////////
  assign tv_fetch = tv_v_r & (tv_req_r.op == e_icache_fetch);
  assign tv_hit   = tv_fetch & (|tv_hit_r);
  assign tv_miss  = tv_fetch & ~(|tv_hit_r);

  assign hit_update_o = {num_ways{tv_fetch}} & tv_hit_r;
  assign fencei_o     = tv_v_r & (tv_req_r.op == e_icache_fencei);

  assign miss_o      = tv_miss;
  assign miss_addr_o = tv_req_r.addr;
  assign miss_way_o  = tv_victim_r;

  // Closed from the miss cycle until the fill is over
  assign ready_o = ~refill_busy_i & ~tv_miss;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      tl_v_r   <= 1'b0;
      tv_v_r   <= 1'b0;
      data_v_o <= 1'b0;
      miss_v_o <= 1'b0;
    end
    else
    begin
      tl_v_r   <= accept;
      // A miss squashes the younger request
      tv_v_r   <= tl_v_r & ~tv_miss;
      data_v_o <= tv_hit;
      miss_v_o <= tv_miss;
    end
  end

  // Stage payloads held in verify through a fill
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      tl_req_r <= req_i;
    end
    if (tl_v_r & ~tv_miss)
    begin
      tv_req_r    <= tl_req_r;
      tv_hit_r    <= hit_way_i;
      tv_victim_r <= victim_way_i;
      tv_word_r   <= tl_word;
    end
    if (tv_hit)
    begin
      data_o <= tv_word_r;
    end
  end

  // A new miss only reaches an idle refill engine
  miss_while_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    miss_o |-> !refill_busy_i);

endmodule

//--- design/icache_pkg.sv
/* Shared definitions of the instruction cache
 * Geometry localparams, address union, operation enum
 * Request, Wishbone and refill-write structs
 */
package icache_pkg;

  ////////////////////////////////
  // Geometry
  ////////////////////////////////
  localparam int addr_width      = 16;
  localparam int instr_width     = 32;
  localparam int num_ways        = 2;
  localparam int num_sets        = 64;
  localparam int words_per_block = 4;

  localparam int index_width     = $clog2(num_sets);
  localparam int word_sel_width  = $clog2(words_per_block);
  localparam int byte_off_width  = $clog2(instr_width / 8);
  localparam int tag_width       = addr_width - index_width - word_sel_width - byte_off_width;
  localparam int way_width       = $clog2(num_ways);

  ////////////////////////////////
  // Address views
  ////////////////////////////////
  typedef struct packed {
    logic [tag_width-1:0]      tag;
    logic [index_width-1:0]    index;
    logic [word_sel_width-1:0] word_sel;
    logic [byte_off_width-1:0] byte_off;
  } icache_addr_fields_s;

  // Raw word on the ports, split fields inside the cache
  typedef union packed {
    logic [addr_width-1:0] raw;
    icache_addr_fields_s   fields;
  } icache_addr_u;

  typedef enum logic {
    e_icache_fetch  = 1'b0,
    e_icache_fencei = 1'b1
  } icache_op_e;

  typedef struct packed {
    icache_op_e   op;
    icache_addr_u addr;
  } icache_req_s;

  ////////////////////////////////
  // Wishbone classic, read only
  ////////////////////////////////
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic [addr_width-1:0] adr;
  } wb_m2s_s;

  typedef struct packed {
    logic                   ack;
    logic [instr_width-1:0] dat;
  } wb_s2m_s;

  // One refill word, also carries way and set for the final tag write
  typedef struct packed {
    logic                      v;
    logic [way_width-1:0]      way;
    logic [index_width-1:0]    index;
    logic [word_sel_width-1:0] word_sel;
    logic [instr_width-1:0]    data;
  } refill_wr_s;

endpackage

//--- design/icache_refill_engine.sv
/* Refill engine of the instruction cache
 * Idle, read and finish FSM with a word counter
 * Wishbone classic reads of one block, word writes and final tag write
 */
`timescale 1ns/1ns

module icache_refill_engine
  (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             miss_i,
  input  icache_pkg::icache_addr_u         miss_addr_i,
  input  logic [icache_pkg::way_width-1:0] miss_way_i,
  output logic                             busy_o,
  output icache_pkg::refill_wr_s           refill_o,
  output logic                             refill_done_o,
  output icache_pkg::wb_m2s_s              wb_o,
  input  icache_pkg::wb_s2m_s              wb_i
  );

  import icache_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_finish
  } state_e;

  state_e                    state_r;
  logic [word_sel_width-1:0] word_cnt_r;
  logic [tag_width-1:0]      tag_r;
  logic [index_width-1:0]    index_r;
  logic [way_width-1:0]      way_r;
  icache_addr_u              fill_addr;
  logic                      reading;
  logic                      last_word;

  assign reading   = (state_r == st_read);
  assign last_word = (word_cnt_r == word_sel_width'(words_per_block - 1));
  assign busy_o    = (state_r != st_idle);

  ////////////////////////////////
  // Wishbone master
  ////////////////////////////////
  always_comb
  begin
    fill_addr.fields.tag      = tag_r;
    fill_addr.fields.index    = index_r;
    fill_addr.fields.word_sel = word_cnt_r;
    fill_addr.fields.byte_off = '0;
  end

  assign wb_o.cyc = reading;
  assign wb_o.stb = reading;
  assign wb_o.adr = fill_addr.raw;

  // Each acked word goes straight into the data store
  always_comb
  begin
    refill_o.v        = reading & wb_i.ack;
    refill_o.way      = way_r;
    refill_o.index    = index_r;
    refill_o.word_sel = word_cnt_r;
    refill_o.data     = wb_i.dat;
  end

  assign refill_done_o = (state_r == st_finish);

  ////////////////////////////////
  // FSM
  ////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r    <= st_idle;
      word_cnt_r <= '0;
    end
    else
    begin
      case (state_r)
        st_idle:
        begin
          if (miss_i)
          begin
            state_r    <= st_read;
            word_cnt_r <= '0;
          end
        end
        st_read:
        begin
          if (wb_i.ack)
          begin
            word_cnt_r <= word_cnt_r + 1'b1;
            if (last_word)
            begin
              state_r <= st_finish;
            end
          end
        end
        default:
        begin
          state_r <= st_idle;
        end
      endcase
    end
  end

  // Block address and target way of the miss
  always_ff @(posedge clk_i)
  begin
    if ((state_r == st_idle) && miss_i)
    begin
      tag_r   <= miss_addr_i.fields.tag;
      index_r <= miss_addr_i.fields.index;
      way_r   <= miss_way_i;
    end
  end

  // Address held steady until the slave acks
  wb_hold_until_ack: assert property (@(posedge clk_i) disable iff (reset_i)
    (wb_o.stb && !wb_i.ack) |=> (wb_o.stb && $stable(wb_o.adr)));

endmodule

//--- design/icache_tag_store.sv
/* Tag store of the instruction cache
 * Tag array, valid flops and one LRU bit per set
 * Lookup with hit and victim, refill tag write, fence.i invalidate
 */
`timescale 1ns/1ns

module icache_tag_store
  (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              lookup_v_i,
  input  icache_pkg::icache_addr_u          lookup_addr_i,
  input  logic [icache_pkg::tag_width-1:0]  verify_tag_i,
  output logic [icache_pkg::num_ways-1:0]   hit_way_o,
  output logic [icache_pkg::way_width-1:0]  victim_way_o,
  input  logic [icache_pkg::num_ways-1:0]   hit_update_i,
  input  logic                              fencei_i,
  input  icache_pkg::refill_wr_s            refill_i,
  input  logic                              refill_done_i
  );

  import icache_pkg::*;

  logic [num_ways-1:0][tag_width-1:0] tag_mem [num_sets];
  logic [num_ways-1:0][tag_width-1:0] tag_rd_r;
  logic [num_sets-1:0][num_ways-1:0]  valid_r;
  // Way to evict next
  logic [num_sets-1:0]                lru_r;

  logic [index_width-1:0]             idx_tl_r;
  logic [index_width-1:0]             idx_tv_r;
  logic [num_ways-1:0]                way_valid;
  logic                               lru_fwd;

  ////////////////////////////////
  // Lookup
  ////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (refill_done_i)
    begin
      tag_mem[refill_i.index][refill_i.way] <= verify_tag_i;
    end
    if (lookup_v_i)
    begin
      tag_rd_r <= tag_mem[lookup_addr_i.fields.index];
      idx_tl_r <= lookup_addr_i.fields.index;
    end
    idx_tv_r <= idx_tl_r;
  end

  // Valid and LRU read live, so the older verify stage is seen at once
  always_comb
  begin
    for (int w = 0; w < num_ways; w++)
    begin
      way_valid[w] = valid_r[idx_tl_r][w] & ~fencei_i;
      hit_way_o[w] = way_valid[w] & (tag_rd_r[w] == verify_tag_i);
    end
  end

  // Hit of the older request on the same set
  assign lru_fwd = (|hit_update_i && (idx_tv_r == idx_tl_r)) ? hit_update_i[0]
                                                              : lru_r[idx_tl_r];

  // First invalid way wins over the LRU way
  always_comb
  begin
    victim_way_o = lru_fwd;
    for (int w = num_ways - 1; w >= 0; w--)
    begin
      if (!way_valid[w])
      begin
        victim_way_o = way_width'(w);
      end
    end
  end

  ////////////////////////////////
  // Valid and LRU update
  ////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      valid_r <= '0;
      lru_r   <= '0;
    end
    else
    begin
      if (fencei_i)
      begin
        valid_r <= '0;
      end
      else if (refill_done_i)
      begin
        valid_r[refill_i.index][refill_i.way] <= 1'b1;
      end
      if (refill_done_i)
      begin
        lru_r[refill_i.index] <= ~refill_i.way;
      end
      else if (|hit_update_i)
      begin
        lru_r[idx_tv_r] <= hit_update_i[0];
      end
    end
  end

  // A block never sits in two ways of one set
  hit_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(hit_way_o));

endmodule

//--- design/icache_top.sv
/* Instruction cache top level
 * Fetch pipe, tag store, data store and refill engine
 */
`timescale 1ns/1ns

module icache_top
  (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  icache_pkg::icache_req_s            req_i,
  input  logic                               v_i,
  output logic                               ready_o,
  output logic [icache_pkg::instr_width-1:0] data_o,
  output logic                               data_v_o,
  output logic                               miss_v_o,
  output icache_pkg::wb_m2s_s                wb_o,
  input  icache_pkg::wb_s2m_s                wb_i
  );

  import icache_pkg::*;

  logic                                  lookup_v;
  icache_addr_u                          lookup_addr;
  logic [tag_width-1:0]                  verify_tag;
  logic [num_ways-1:0]                   hit_way;
  logic [way_width-1:0]                  victim_way;
  logic [num_ways-1:0]                   hit_update;
  logic                                  fencei;
  logic [num_ways-1:0][instr_width-1:0]  way_data;
  logic                                  miss;
  icache_addr_u                          miss_addr;
  logic [way_width-1:0]                  miss_way;
  logic                                  refill_busy;
  refill_wr_s                            refill;
  logic                                  refill_done;

  icache_fetch_pipe pipe0
    (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_i         (req_i),
    .v_i           (v_i),
    .ready_o       (ready_o),
    .data_o        (data_o),
    .data_v_o      (data_v_o),
    .miss_v_o      (miss_v_o),
    .lookup_v_o    (lookup_v),
    .lookup_addr_o (lookup_addr),
    .verify_tag_o  (verify_tag),
    .hit_way_i     (hit_way),
    .victim_way_i  (victim_way),
    .hit_update_o  (hit_update),
    .fencei_o      (fencei),
    .way_data_i    (way_data),
    .miss_o        (miss),
    .miss_addr_o   (miss_addr),
    .miss_way_o    (miss_way),
    .refill_busy_i (refill_busy)
    );

  icache_tag_store tags0
    (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .lookup_v_i    (lookup_v),
    .lookup_addr_i (lookup_addr),
    .verify_tag_i  (verify_tag),
    .hit_way_o     (hit_way),
    .victim_way_o  (victim_way),
    .hit_update_i  (hit_update),
    .fencei_i      (fencei),
    .refill_i      (refill),
    .refill_done_i (refill_done)
    );

  icache_data_store data0
    (
    .clk_i      (clk_i),
    .rd_v_i     (lookup_v),
    .rd_addr_i  (lookup_addr),
    .way_data_o (way_data),
    .refill_i   (refill)
    );

  icache_refill_engine refill0
    (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .miss_i        (miss),
    .miss_addr_i   (miss_addr),
    .miss_way_i    (miss_way),
    .busy_o        (refill_busy),
    .refill_o      (refill),
    .refill_done_o (refill_done),
    .wb_o          (wb_o),
    .wb_i          (wb_i)
    );

endmodule

//--- testbench/tb_icache.sv
/* Testbench top for the instruction cache
 * Clock, reset, directed tests and a tag, valid and LRU model
 * Compare tasks and cycle timeout
 */
`timescale 1ns/1ns

module tb_icache;

  import icache_pkg::*;

  // About 150 fetches of at most 25 cycles each
  localparam int max_cycles = 4000;

  logic                   clk_i;
  logic                   reset_i;
  icache_req_s            req;
  logic                   v;
  logic                   ready;
  logic [instr_width-1:0] data;
  logic                   data_v;
  logic                   miss_v;
  wb_m2s_s                wb_m2s;
  wb_s2m_s                wb_s2m;
  int                     cycle_cnt = 0;

  // Reference model of tags, valid bits and LRU per set
  logic [5:0] model_tag [64][2];
  logic [1:0] model_valid [64];
  logic       model_lru [64];

  icache_top dut0
    (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (req),
    .v_i      (v),
    .ready_o  (ready),
    .data_o   (data),
    .data_v_o (data_v),
    .miss_v_o (miss_v),
    .wb_o     (wb_m2s),
    .wb_i     (wb_s2m)
    );

  tb_wb_memory mem0
    (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .wb_i    (wb_m2s),
    .wb_o    (wb_s2m)
    );

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles)
    begin
      $display("Run stopped, no progress after %0d cycles", cycle_cnt);
      $display("SOME TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////
  // Compare tasks
  //////////////////////////////
  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at the first error");
    end
  endtask

  task automatic check_instr(input string name, input logic [instr_width-1:0] got,
                             input logic [instr_width-1:0] exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at the first error");
    end
  endtask

  //////////////////////////////
  // Rules and helpers
  //////////////////////////////
  function automatic logic [instr_width-1:0] mem_word(input logic [addr_width-1:0] a);
    return {16'hc0de, a};
  endfunction

  function automatic logic [addr_width-1:0] line_addr(input int tag, input int idx,
                                                      input int word);
    return {6'(tag), 6'(idx), 2'(word), 2'b00};
  endfunction

  function automatic int model_lookup(input logic [addr_width-1:0] a);
    int found;
    found = -1;
    for (int w = 0; w < 2; w++)
    begin
      if (model_valid[a[9:4]][w] && (model_tag[a[9:4]][w] == a[15:10]))
        found = w;
    end
    return found;
  endfunction

  // Invalid way first, else the LRU way
  function automatic int model_fill(input logic [addr_width-1:0] a);
    int w;
    if (!model_valid[a[9:4]][0])
      w = 0;
    else if (!model_valid[a[9:4]][1])
      w = 1;
    else
      w = model_lru[a[9:4]];
    model_valid[a[9:4]][w] = 1'b1;
    model_tag[a[9:4]][w]   = a[15:10];
    model_lru[a[9:4]]      = (w == 0);
    return w;
  endfunction

  task automatic wait_ready;
    while (!ready)
    begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // Holds the request until it is accepted
  task automatic send_req(input icache_op_e op, input logic [addr_width-1:0] addr);
    req.op       = op;
    req.addr.raw = addr;
    v            = 1'b1;
    wait_ready();
    @(posedge clk_i);
    #1;
    v = 1'b0;
  endtask

  task automatic fetch_once(input logic [addr_width-1:0] addr, input logic exp_hit);
    send_req(e_icache_fetch, addr);
    @(posedge clk_i);
    #1;
    // Request in verify
    check_flag("ready_o", ready, exp_hit);
    check_flag("data_v_o", data_v, 1'b0);
    check_flag("miss_v_o", miss_v, 1'b0);
    @(posedge clk_i);
    #1;
    check_flag("data_v_o", data_v, exp_hit);
    check_flag("miss_v_o", miss_v, ~exp_hit);
    if (exp_hit)
      check_instr("data_o", data, mem_word(addr));
    else
      wait_ready();
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////
  task automatic test_miss_then_hit(input logic [addr_width-1:0] addr);
    fetch_once(addr, 1'b0);
    fetch_once(addr, 1'b1);
  endtask

  // Four back-to-back fetches with results three loop steps behind
  task automatic test_block_burst(input logic [addr_width-1:0] base);
    fetch_once(base, 1'b0);
    for (int i = 0; i < 8; i++)
    begin
      if (i < 4)
      begin
        req.op       = e_icache_fetch;
        req.addr.raw = base + 16'(4 * i);
        v            = 1'b1;
        check_flag("ready_o", ready, 1'b1);
      end
      else
        v = 1'b0;
      check_flag("miss_v_o", miss_v, 1'b0);
      check_flag("data_v_o", data_v, (i >= 3) && (i < 7));
      if ((i >= 3) && (i < 7))
        check_instr("data_o", data, mem_word(base + 16'(4 * (i - 3))));
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic test_lru_evict(input int idx);
    logic [addr_width-1:0] a1, a2, a3;
    a1 = line_addr(1, idx, 0);
    a2 = line_addr(2, idx, 0);
    a3 = line_addr(3, idx, 0);
    fetch_once(a1, 1'b0);
    fetch_once(a2, 1'b0);
    fetch_once(a1, 1'b1);
    fetch_once(a3, 1'b0);
    fetch_once(a1, 1'b1);
    fetch_once(a2, 1'b0);
  endtask

  task automatic test_fence(input logic [addr_width-1:0] a, input logic [addr_width-1:0] b);
    fetch_once(a, 1'b1);
    fetch_once(b, 1'b1);
    send_req(e_icache_fencei, '0);
    fetch_once(a, 1'b0);
    fetch_once(b, 1'b0);
  endtask

  // The hit request behind a miss must vanish
  task automatic test_squash(input logic [addr_width-1:0] miss_a,
                             input logic [addr_width-1:0] hit_a);
    for (int i = 0; i < 5; i++)
    begin
      if (i < 2)
      begin
        req.op       = e_icache_fetch;
        req.addr.raw = (i == 0) ? miss_a : hit_a;
        v            = 1'b1;
        check_flag("ready_o", ready, 1'b1);
      end
      else
        v = 1'b0;
      if (i == 2)
        check_flag("ready_o", ready, 1'b0);
      check_flag("data_v_o", data_v, 1'b0);
      check_flag("miss_v_o", miss_v, i == 3);
      @(posedge clk_i);
      #1;
    end
    wait_ready();
    fetch_once(miss_a, 1'b1);
    fetch_once(hit_a, 1'b1);
  endtask

  task automatic test_random(input int n);
    logic [addr_width-1:0] a;
    int way;
    send_req(e_icache_fencei, '0);
    foreach (model_valid[s])
      model_valid[s] = 2'b00;
    repeat (n)
    begin
      a   = line_addr($urandom_range(3, 1), $urandom_range(15, 8), $urandom_range(3, 0));
      way = model_lookup(a);
      if (way < 0)
      begin
        fetch_once(a, 1'b0);
        way = model_fill(a);
      end
      fetch_once(a, 1'b1);
      model_lru[a[9:4]] = (way == 0);
    end
  endtask

  initial
  begin
    void'($urandom(32'hfe5));
    reset_i = 1'b1;
    v       = 1'b0;
    req     = '0;
    foreach (model_lru[s])
      model_lru[s] = 1'b0;
    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    check_flag("ready_o", ready, 1'b1);
    check_flag("data_v_o", data_v, 1'b0);
    check_flag("miss_v_o", miss_v, 1'b0);
    check_flag("wb_o.cyc", wb_m2s.cyc, 1'b0);
    check_flag("wb_o.stb", wb_m2s.stb, 1'b0);
    test_miss_then_hit(16'h1230);
    test_block_burst(16'h2340);
    test_lru_evict(5);
    test_fence(16'h1230, 16'h2340);
    test_squash(16'h3a60, 16'h1238);
    test_random(120);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- testbench/tb_wb_memory.sv
/* Wishbone classic slave memory model
 * Word at byte address a reads as 16'hc0de followed by a
 * Registered ack after zero to three random wait states
 */
`timescale 1ns/1ns

module tb_wb_memory
  (
  input  logic                clk_i,
  input  logic                reset_i,
  input  icache_pkg::wb_m2s_s wb_i,
  output icache_pkg::wb_s2m_s wb_o
  );

  import icache_pkg::*;

  localparam int max_wait = 3;

  logic        pending_r;
  int unsigned wait_r;
  int unsigned waits;

  always @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wb_o      <= '0;
      pending_r <= 1'b0;
      wait_r    <= 0;
    end
    else if (wb_o.ack)
    begin
      // One ack per word, the master then moves to the next address
      wb_o.ack <= 1'b0;
    end
    else if (wb_i.cyc && wb_i.stb)
    begin
      // New read draws its wait count
      waits = pending_r ? wait_r : $urandom_range(max_wait, 0);
      if (waits == 0)
      begin
        wb_o.ack  <= 1'b1;
        wb_o.dat  <= {16'hc0de, wb_i.adr};
        pending_r <= 1'b0;
      end
      else
      begin
        pending_r <= 1'b1;
        wait_r    <= waits - 1;
      end
    end
  end

endmodule

//--- vlog.f
design/icache_pkg.sv
design/icache_fetch_pipe.sv
design/icache_tag_store.sv
design/icache_data_store.sv
design/icache_refill_engine.sv
design/icache_top.sv
testbench/tb_wb_memory.sv
testbench/tb_icache.sv
